/* src/soc_harness_defs.svh */
`ifndef SOC_HARNESS_DEFS_SVH
`define SOC_HARNESS_DEFS_SVH

// bus widths
`define SH_ADDR_W       32
`define SH_DATA_W       64
`define SH_BE_W         8
`define SH_XLEN         64

// ----------------------------------------------------------
// address map
// ----------------------------------------------------------
`define SH_SRAM_BASE    32'h8000_0000
`define SH_SRAM_WORDS   512
`define SH_CLINT_BASE   32'h0200_0000
`define SH_CLINT_LEN    32'h0001_0000
`define SH_GPIO_BASE    32'h4000_0000
`define SH_GPIO_LEN     32'h0000_1000

// clint register offsets within its window
`define SH_MSIP_OFS     16'h0000
`define SH_MTIMECMP_OFS 16'h4000
`define SH_MTIME_OFS    16'hBFF8

`define SH_IRQ_ID_W     6
// cycles of debug hold-off after reset, short for simulation
`define SH_DBG_DELAY    16

`endif

/* src/soc_harness_pkg.sv */
`include "soc_harness_defs.svh"

package soc_harness_pkg;

  // ----------------------------------------------------------
  // bus payload types
  // ----------------------------------------------------------
  typedef logic [`SH_ADDR_W-1:0] addr_t;
  typedef logic [`SH_DATA_W-1:0] data_t;
  typedef logic [`SH_BE_W-1:0]   be_t;

  // ----------------------------------------------------------
  // interrupt types
  // ----------------------------------------------------------
  // machine-level pending vector, one bit per interrupt cause
  typedef logic [`SH_XLEN-1:0]     xlen_t;
  typedef logic [`SH_IRQ_ID_W-1:0] irq_id_t;

  // exit code as reported by the jtag or dmi side
  typedef logic [31:0] exit_t;

  // decoder target for the current request
  typedef enum logic [1:0] {
    SEL_SRAM,
    SEL_CLINT,
    SEL_ERR
  } slave_sel_e;

endpackage

/* src/mem_bus_if.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

// single request/response slave bus, no back-pressure
interface mem_bus_if;

  logic                   req;
  logic                   we;
  logic [`SH_ADDR_W-1:0]  addr;
  logic [`SH_BE_W-1:0]    be;
  logic [`SH_DATA_W-1:0]  wdata;
  // valid the cycle after a read request
  logic [`SH_DATA_W-1:0]  rdata;

  modport host (
    output req,
    output we,
    output addr,
    output be,
    output wdata,
    input  rdata
  );

  modport dev (
    input  req,
    input  we,
    input  addr,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

/* src/bus_decoder.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

module bus_decoder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  soc_harness_pkg::addr_t bus_addr_i,
  input  soc_harness_pkg::be_t   bus_be_i,
  input  soc_harness_pkg::data_t bus_wdata_i,
  output logic                   bus_rvalid_o,
  output soc_harness_pkg::data_t bus_rdata_o,
  output logic                   bus_err_o,
  mem_bus_if.host                sram_bus,
  mem_bus_if.host                clint_bus
);

  localparam soc_harness_pkg::addr_t sram_bytes = `SH_SRAM_WORDS * `SH_BE_W;

  soc_harness_pkg::addr_t     sram_ofs, clint_ofs, gpio_ofs;
  logic                       sram_hit, clint_hit, gpio_hit;
  soc_harness_pkg::slave_sel_e sel_d, sel_q;
  logic                       valid_q;
  logic                       we_q;

  // offsets wrap below the base, so one compare per window is enough
  assign sram_ofs  = bus_addr_i - `SH_SRAM_BASE;
  assign clint_ofs = bus_addr_i - `SH_CLINT_BASE;
  assign gpio_ofs  = bus_addr_i - `SH_GPIO_BASE;

  assign sram_hit  = sram_ofs < sram_bytes;
  assign clint_hit = clint_ofs < `SH_CLINT_LEN;
  assign gpio_hit  = gpio_ofs < `SH_GPIO_LEN;

  // gpio has no slave behind it and answers like an unmapped hole
  always_comb begin
    sel_d = soc_harness_pkg::SEL_ERR;
    if (gpio_hit) begin
      sel_d = soc_harness_pkg::SEL_ERR;
    end else if (sram_hit) begin
      sel_d = soc_harness_pkg::SEL_SRAM;
    end else if (clint_hit) begin
      sel_d = soc_harness_pkg::SEL_CLINT;
    end
  end

  // ----------------------------------------------------------
  // request steering
  // ----------------------------------------------------------
  assign sram_bus.req   = bus_req_i && (sel_d == soc_harness_pkg::SEL_SRAM);
  assign sram_bus.we    = bus_we_i;
  assign sram_bus.addr  = sram_ofs;
  assign sram_bus.be    = bus_be_i;
  assign sram_bus.wdata = bus_wdata_i;

  assign clint_bus.req   = bus_req_i && (sel_d == soc_harness_pkg::SEL_CLINT);
  assign clint_bus.we    = bus_we_i;
  assign clint_bus.addr  = clint_ofs;
  assign clint_bus.be    = bus_be_i;
  assign clint_bus.wdata = bus_wdata_i;

  // ----------------------------------------------------------
  // response cycle
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      sel_q   <= soc_harness_pkg::SEL_ERR;
    end else begin
      valid_q <= bus_req_i;
      we_q    <= bus_we_i;
      sel_q   <= sel_d;
    end
  end

  always_comb begin
    bus_rdata_o = '0;
    if (valid_q && !we_q) begin
      case (sel_q)
        soc_harness_pkg::SEL_SRAM:  bus_rdata_o = sram_bus.rdata;
        soc_harness_pkg::SEL_CLINT: bus_rdata_o = clint_bus.rdata;
        default:                    bus_rdata_o = '0;
      endcase
    end
  end

  assign bus_rvalid_o = valid_q;
  assign bus_err_o    = valid_q && (sel_q == soc_harness_pkg::SEL_ERR);

endmodule

/* src/sram_bank.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

module sram_bank (
  input  logic   clk_i,
  mem_bus_if.dev bus
);

  localparam int unsigned idx_w = $clog2(`SH_SRAM_WORDS);
  localparam int unsigned ofs_w = $clog2(`SH_BE_W);

  soc_harness_pkg::data_t mem [`SH_SRAM_WORDS];
  logic [idx_w-1:0]       word_idx;

  // drop the byte offset, the decoder already made the address window relative
  assign word_idx = bus.addr[idx_w+ofs_w-1:ofs_w];

  // ----------------------------------------------------------
  // write with byte enables, registered read
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int i = 0; i < `SH_BE_W; i++) begin
          if (bus.be[i]) begin
            mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end else begin
        bus.rdata <= mem[word_idx];
      end
    end
  end

endmodule

/* src/clint_regs.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

module clint_regs (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   rtc_i,
  mem_bus_if.dev bus,
  output logic   timer_irq_o,
  output logic   soft_irq_o
);

  logic [15:0]            reg_ofs;
  logic                   wr_msip, wr_mtimecmp, wr_mtime;
  logic [2:0]             rtc_sync_q;
  logic                   rtc_rise;
  logic                   msip_q;
  logic                   timer_irq_q;
  soc_harness_pkg::data_t mtime_q;
  soc_harness_pkg::data_t mtimecmp_q;

  function automatic soc_harness_pkg::data_t merge_bytes(
    input soc_harness_pkg::data_t old_val,
    input soc_harness_pkg::data_t new_val,
    input soc_harness_pkg::be_t   be
  );
    soc_harness_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < `SH_BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // registers are 64-bit aligned
  assign reg_ofs     = {bus.addr[15:3], 3'b000};
  assign wr_msip     = bus.req && bus.we && (reg_ofs == `SH_MSIP_OFS);
  assign wr_mtimecmp = bus.req && bus.we && (reg_ofs == `SH_MTIMECMP_OFS);
  assign wr_mtime    = bus.req && bus.we && (reg_ofs == `SH_MTIME_OFS);

  // ----------------------------------------------------------
  // rtc synchronizer, two flops plus one for edge detect
  // ----------------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] && !rtc_sync_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q  <= '0;
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      timer_irq_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      if (wr_msip && bus.be[0]) begin
        msip_q <= bus.wdata[0];
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, bus.wdata, bus.be);
      end
      // a software write beats a tick in the same cycle
      if (wr_mtime) begin
        mtime_q <= merge_bytes(mtime_q, bus.wdata, bus.be);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // read port, unknown offsets read zero
  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      case (reg_ofs)
        `SH_MSIP_OFS:     bus.rdata <= {{(`SH_DATA_W-1){1'b0}}, msip_q};
        `SH_MTIMECMP_OFS: bus.rdata <= mtimecmp_q;
        `SH_MTIME_OFS:    bus.rdata <= mtime_q;
        default:          bus.rdata <= '0;
      endcase
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign soft_irq_o  = msip_q;

endmodule

/* src/irq_router.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

module irq_router (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [1:0]               ext_irq_i,
  input  logic                     timer_irq_i,
  input  logic                     soft_irq_i,
  output logic                     irq_valid_o,
  output soc_harness_pkg::irq_id_t irq_id_o,
  output soc_harness_pkg::xlen_t   irq_onehot_o
);

  soc_harness_pkg::xlen_t   pending;
  soc_harness_pkg::irq_id_t id_d;
  soc_harness_pkg::xlen_t   onehot_d;

  // standard mip layout, msip 3, mtip 7, seip 9, meip 11
  always_comb begin
    pending     = '0;
    pending[3]  = soft_irq_i;
    pending[7]  = timer_irq_i;
    pending[9]  = ext_irq_i[1];
    pending[11] = ext_irq_i[0];
  end

  // highest set bit wins
  always_comb begin
    id_d     = '0;
    onehot_d = '0;
    for (int i = 0; i < `SH_XLEN; i++) begin
      if (pending[i]) begin
        id_d = soc_harness_pkg::irq_id_t'(i);
      end
    end
    if (|pending) begin
      onehot_d[id_d] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_valid_o  <= 1'b0;
      irq_id_o     <= '0;
      irq_onehot_o <= '0;
    end else begin
      irq_valid_o  <= |pending;
      irq_id_o     <= id_d;
      irq_onehot_o <= onehot_d;
    end
  end

endmodule

/* src/debug_gate.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

module debug_gate (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   dbg_jtag_sel_i,
  input  logic                   dbg_enable_i,
  input  logic                   jtag_dbg_req_i,
  input  logic                   dmi_dbg_req_i,
  input  soc_harness_pkg::exit_t jtag_exit_i,
  input  soc_harness_pkg::exit_t dmi_exit_i,
  output logic                   debug_req_o,
  output soc_harness_pkg::exit_t exit_o
);

  localparam int unsigned cnt_w = $clog2(`SH_DBG_DELAY + 1);

  logic [cnt_w-1:0] delay_cnt_q;
  logic             src_req;
  logic             hold_off;

  // ----------------------------------------------------------
  // post-reset hold-off
  // ----------------------------------------------------------
  // gives the core time to run its boot code before the first halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_cnt_q <= cnt_w'(`SH_DBG_DELAY);
    end else if (delay_cnt_q != '0) begin
      delay_cnt_q <= delay_cnt_q - 1'b1;
    end
  end

  assign hold_off = (delay_cnt_q != '0);

  // ----------------------------------------------------------
  // source selection
  // ----------------------------------------------------------
  assign src_req     = dbg_jtag_sel_i ? jtag_dbg_req_i : dmi_dbg_req_i;
  assign debug_req_o = !hold_off && dbg_enable_i && src_req;

  // exit code follows the same source as the debug request
  assign exit_o = dbg_jtag_sel_i ? jtag_exit_i : dmi_exit_i;

endmodule

/* src/soc_harness_top.sv */
`timescale 1ns/1ns

module soc_harness_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rtc_i,
  // host bus
  input  logic                     bus_req_i,
  input  logic                     bus_we_i,
  input  soc_harness_pkg::addr_t   bus_addr_i,
  input  soc_harness_pkg::be_t     bus_be_i,
  input  soc_harness_pkg::data_t   bus_wdata_i,
  output logic                     bus_rvalid_o,
  output logic                     bus_err_o,
  output soc_harness_pkg::data_t   bus_rdata_o,
  // interrupts, bit 0 meip and bit 1 seip
  input  logic [1:0]               ext_irq_i,
  output logic                     irq_valid_o,
  output soc_harness_pkg::irq_id_t irq_id_o,
  output soc_harness_pkg::xlen_t   irq_onehot_o,
  // debug
  input  logic                     dbg_jtag_sel_i,
  input  logic                     dbg_enable_i,
  input  logic                     jtag_dbg_req_i,
  input  logic                     dmi_dbg_req_i,
  input  soc_harness_pkg::exit_t   jtag_exit_i,
  input  soc_harness_pkg::exit_t   dmi_exit_i,
  output logic                     debug_req_o,
  output soc_harness_pkg::exit_t   exit_o
);

  logic timer_irq;
  logic soft_irq;

  mem_bus_if sram_bus ();
  mem_bus_if clint_bus ();

  // ----------------------------------------------------------
  // memory bus
  // ----------------------------------------------------------
  bus_decoder i_bus_decoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .bus_req_i    ( bus_req_i    ),
    .bus_we_i     ( bus_we_i     ),
    .bus_addr_i   ( bus_addr_i   ),
    .bus_be_i     ( bus_be_i     ),
    .bus_wdata_i  ( bus_wdata_i  ),
    .bus_rvalid_o ( bus_rvalid_o ),
    .bus_rdata_o  ( bus_rdata_o  ),
    .bus_err_o    ( bus_err_o    ),
    .sram_bus     ( sram_bus     ),
    .clint_bus    ( clint_bus    )
  );

  sram_bank i_sram_bank (
    .clk_i ( clk_i    ),
    .bus   ( sram_bus )
  );

  clint_regs i_clint_regs (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .rtc_i       ( rtc_i     ),
    .bus         ( clint_bus ),
    .timer_irq_o ( timer_irq ),
    .soft_irq_o  ( soft_irq  )
  );

  // ----------------------------------------------------------
  // interrupts and debug
  // ----------------------------------------------------------
  irq_router i_irq_router (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ext_irq_i    ( ext_irq_i    ),
    .timer_irq_i  ( timer_irq    ),
    .soft_irq_i   ( soft_irq     ),
    .irq_valid_o  ( irq_valid_o  ),
    .irq_id_o     ( irq_id_o     ),
    .irq_onehot_o ( irq_onehot_o )
  );

  debug_gate i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .dbg_jtag_sel_i ( dbg_jtag_sel_i ),
    .dbg_enable_i   ( dbg_enable_i   ),
    .jtag_dbg_req_i ( jtag_dbg_req_i ),
    .dmi_dbg_req_i  ( dmi_dbg_req_i  ),
    .jtag_exit_i    ( jtag_exit_i    ),
    .dmi_exit_i     ( dmi_exit_i     ),
    .debug_req_o    ( debug_req_o    ),
    .exit_o         ( exit_o         )
  );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

endmodule

/* test/tb_soc_harness.sv */
`timescale 1ns/1ns
`include "soc_harness_defs.svh"

module tb_soc_harness;

  localparam int unsigned max_cycles = 4000;

  logic clk_i, rst_ni, rtc_i, bus_req_i, bus_we_i, bus_rvalid_o, bus_err_o;
  soc_harness_pkg::addr_t   bus_addr_i;
  soc_harness_pkg::be_t     bus_be_i;
  soc_harness_pkg::data_t   bus_wdata_i, bus_rdata_o;
  logic [1:0]               ext_irq_i;
  logic                     irq_valid_o;
  soc_harness_pkg::irq_id_t irq_id_o;
  soc_harness_pkg::xlen_t   irq_onehot_o;
  logic dbg_jtag_sel_i, dbg_enable_i, jtag_dbg_req_i, dmi_dbg_req_i, debug_req_o;
  soc_harness_pkg::exit_t   jtag_exit_i, dmi_exit_i, exit_o;

  // byte-level sram model and the expected responses in request order
  logic [7:0]             sram_model [`SH_SRAM_WORDS*`SH_BE_W];
  logic                   exp_err_q [$];
  soc_harness_pkg::data_t exp_data_q [$];
  int unsigned            err_cnt = 0;
  int unsigned            cycle_cnt = 0;
  int unsigned            post_rst_cnt = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk_i));

  soc_harness_top u_soc_harness_top (.*);

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_ni) begin
      post_rst_cnt <= post_rst_cnt + 1;
    end
    if (cycle_cnt == max_cycles) begin
      $display("timeout, the test did not end within %0d cycles", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // bus protocol and response checks
  // ------------------------------------------------------------
  rvalid_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bus_rvalid_o == $past(bus_req_i))
    else begin
      err_cnt++;
      $display("[FAIL] bus_rvalid_o exp %h got %h", !$sampled(bus_rvalid_o),
               $sampled(bus_rvalid_o));
    end

  always @(negedge clk_i) begin : resp_monitor
    logic                   exp_err, exp_dbg;
    soc_harness_pkg::data_t exp_data;
    soc_harness_pkg::exit_t exp_exit;
    if (rst_ni && bus_rvalid_o) begin
      if (exp_err_q.size() == 0) begin
        err_cnt++;
        $display("bus response arrived with no request outstanding");
      end else begin
        exp_err  = exp_err_q.pop_front();
        exp_data = exp_data_q.pop_front();
        err_flag: assert (bus_err_o === exp_err) else begin
          err_cnt++;
          $display("[FAIL] bus_err_o exp %h got %h", exp_err, bus_err_o);
        end
        rdata_val: assert (bus_rdata_o === exp_data) else begin
          err_cnt++;
          $display("[FAIL] bus_rdata_o exp %h got %h", exp_data, bus_rdata_o);
        end
      end
    end
    // hold-off window first, then the selected source gated by the enable
    exp_dbg  = (post_rst_cnt >= `SH_DBG_DELAY) && dbg_enable_i &&
               (dbg_jtag_sel_i ? jtag_dbg_req_i : dmi_dbg_req_i);
    exp_exit = dbg_jtag_sel_i ? jtag_exit_i : dmi_exit_i;
    dbg_req: assert (debug_req_o === exp_dbg) else begin
      err_cnt++;
      $display("[FAIL] debug_req_o exp %h got %h", exp_dbg, debug_req_o);
    end
    exit_val: assert (exit_o === exp_exit) else begin
      err_cnt++;
      $display("[FAIL] exit_o exp %h got %h", exp_exit, exit_o);
    end
  end

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------
  task automatic bus_access(input logic we, input soc_harness_pkg::addr_t addr,
                            input soc_harness_pkg::be_t be,
                            input soc_harness_pkg::data_t wdata,
                            input logic exp_err, input soc_harness_pkg::data_t exp_rdata);
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_be_i    <= be;
    bus_wdata_i <= wdata;
    exp_err_q.push_back(exp_err);
    exp_data_q.push_back((we || exp_err) ? '0 : exp_rdata);
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    bus_req_i <= 1'b0;
  endtask

  function automatic soc_harness_pkg::addr_t sram_addr(input int unsigned word);
    return `SH_SRAM_BASE + word * `SH_BE_W;
  endfunction

  function automatic soc_harness_pkg::addr_t clint_addr(input logic [15:0] ofs);
    return `SH_CLINT_BASE + ofs;
  endfunction

  task automatic sram_write(input int unsigned word, input soc_harness_pkg::be_t be,
                            input soc_harness_pkg::data_t wdata);
    for (int b = 0; b < `SH_BE_W; b++) begin
      if (be[b]) begin
        sram_model[word*`SH_BE_W + b] = wdata[8*b +: 8];
      end
    end
    bus_access(1'b1, sram_addr(word), be, wdata, 1'b0, '0);
  endtask

  task automatic sram_read(input int unsigned word);
    soc_harness_pkg::data_t exp_word;
    for (int b = 0; b < `SH_BE_W; b++) begin
      exp_word[8*b +: 8] = sram_model[word*`SH_BE_W + b];
    end
    bus_access(1'b0, sram_addr(word), 8'hff, '0, 1'b0, exp_word);
  endtask

  // meip 11 over seip 9 over mtip 7 over msip 3 in the mip layout
  task automatic check_irq(input logic [1:0] ext, input logic msip, input logic mtip);
    logic                     exp_valid;
    soc_harness_pkg::irq_id_t exp_id;
    soc_harness_pkg::xlen_t   exp_onehot;
    exp_valid  = |{ext, msip, mtip};
    exp_id     = ext[0] ? 6'd11 : ext[1] ? 6'd9 : mtip ? 6'd7 : 6'd3;
    exp_onehot = exp_valid ? (soc_harness_pkg::xlen_t'(1) << exp_id) : '0;
    @(negedge clk_i);
    irq_valid: assert (irq_valid_o === exp_valid) else begin
      err_cnt++;
      $display("[FAIL] irq_valid_o exp %h got %h", exp_valid, irq_valid_o);
    end
    irq_id: assert (!exp_valid || irq_id_o === exp_id) else begin
      err_cnt++;
      $display("[FAIL] irq_id_o exp %h got %h", exp_id, irq_id_o);
    end
    irq_onehot: assert (irq_onehot_o === exp_onehot) else begin
      err_cnt++;
      $display("[FAIL] irq_onehot_o exp %h got %h", exp_onehot, irq_onehot_o);
    end
  endtask

  // rising edges four or more cycles apart
  task automatic rtc_edges(input int unsigned n);
    repeat (n) begin
      repeat (3) @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (3) @(posedge clk_i);
      rtc_i <= 1'b0;
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    int unsigned n_ticks;
    void'($urandom(32'h3b33));
    rst_ni         <= 1'b0;
    rtc_i          <= 1'b0;
    bus_req_i      <= 1'b0;
    bus_we_i       <= 1'b0;
    bus_addr_i     <= '0;
    bus_be_i       <= '0;
    bus_wdata_i    <= '0;
    ext_irq_i      <= '0;
    dbg_jtag_sel_i <= 1'b1;
    dbg_enable_i   <= 1'b1;
    jtag_dbg_req_i <= 1'b1;
    dmi_dbg_req_i  <= 1'b1;
    jtag_exit_i    <= 32'h0000_00a1;
    dmi_exit_i     <= 32'h0000_00d2;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // sram fill then random traffic that is mostly back to back
    for (int w = 0; w < `SH_SRAM_WORDS; w++) begin
      sram_write(w, 8'hff, {sram_addr(w), ~sram_addr(w)});
    end
    for (int i = 0; i < 300; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        sram_write($urandom_range(`SH_SRAM_WORDS-1, 0), soc_harness_pkg::be_t'($urandom),
                   {$urandom, $urandom});
      end else begin
        sram_read($urandom_range(`SH_SRAM_WORDS-1, 0));
      end
      if ($urandom_range(3, 0) == 0) begin
        bus_idle();
      end
    end

    // gpio window, unmapped holes and the first bytes past each window
    for (int i = 0; i < 8; i++) begin
      bus_access(i[0], `SH_GPIO_BASE + ($urandom % `SH_GPIO_LEN), 8'hff,
                 {$urandom, $urandom}, 1'b1, '0);
      bus_access(i[1], {4'h1, 28'($urandom)}, 8'hff, {$urandom, $urandom}, 1'b1, '0);
    end
    bus_access(1'b0, sram_addr(`SH_SRAM_WORDS), 8'hff, '0, 1'b1, '0);
    bus_access(1'b0, `SH_CLINT_BASE + `SH_CLINT_LEN, 8'hff, '0, 1'b1, '0);
    bus_access(1'b0, clint_addr(16'h0100), 8'hff, '0, 1'b0, '0);

    // mtime counting and the timer interrupt
    n_ticks = $urandom_range(10, 3);
    bus_idle();
    // a few ticks first so the zero write has a count to clear
    rtc_edges(2);
    bus_access(1'b1, clint_addr(`SH_MTIME_OFS), 8'hff, '0, 1'b0, '0);
    bus_idle();
    rtc_edges(n_ticks);
    repeat (4) @(posedge clk_i);
    bus_access(1'b0, clint_addr(`SH_MTIME_OFS), 8'hff, '0, 1'b0, 64'(n_ticks));
    bus_idle();
    check_irq(2'b00, 1'b0, 1'b0);
    bus_access(1'b1, clint_addr(`SH_MTIMECMP_OFS), 8'hff, 64'(n_ticks), 1'b0, '0);
    bus_idle();
    repeat (2) @(posedge clk_i);
    check_irq(2'b00, 1'b0, 1'b1);
    bus_access(1'b1, clint_addr(`SH_MTIMECMP_OFS), 8'hff, 64'(n_ticks + 5), 1'b0, '0);
    bus_idle();
    repeat (2) @(posedge clk_i);
    check_irq(2'b00, 1'b0, 1'b0);

    // every mix of external lines and msip with the timer quiet
    for (int c = 0; c < 8; c++) begin
      bus_access(1'b1, clint_addr(`SH_MSIP_OFS), 8'h01, 64'(c[2]), 1'b0, '0);
      ext_irq_i <= c[1:0];
      bus_idle();
      @(posedge clk_i);
      check_irq(c[1:0], c[2], 1'b0);
    end

    // debug source selection and enable
    repeat (60) begin
      @(posedge clk_i);
      dbg_jtag_sel_i <= $urandom_range(1, 0);
      dbg_enable_i   <= $urandom_range(1, 0);
      jtag_dbg_req_i <= $urandom_range(1, 0);
      dmi_dbg_req_i  <= $urandom_range(1, 0);
      jtag_exit_i    <= $urandom;
      dmi_exit_i     <= $urandom;
    end
    repeat (2) @(posedge clk_i);

    resp_drained: assert (exp_err_q.size() == 0) else begin
      err_cnt++;
      $display("%0d bus requests never got a response", exp_err_q.size());
    end
    $display("checks finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* soc_harness.f */
+incdir+src
src/soc_harness_pkg.sv
src/mem_bus_if.sv
src/bus_decoder.sv
src/sram_bank.sv
src/clint_regs.sv
src/irq_router.sv
src/debug_gate.sv
src/soc_harness_top.sv
test/tb_clk_gen.sv
test/tb_soc_harness.sv

/* Bender.yml */
package:
  name: soc_harness

sources:
  - include_dirs:
      - src
    files:
      - src/soc_harness_pkg.sv
      - src/mem_bus_if.sv
      - src/bus_decoder.sv
      - src/sram_bank.sv
      - src/clint_regs.sv
      - src/irq_router.sv
      - src/debug_gate.sv
      - src/soc_harness_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clk_gen.sv
      - test/tb_soc_harness.sv
